//--- include/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// data path and instruction word width
`define DATA_W 32

// register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// intake queue entries between handshake and issue
`define INTAKE_DEPTH 8

`endif

//--- hw/pipePkg.sv
`default_nettype none

package pipePkg;

	// alu operations after decode
	// ADDI and NOP both map to opAdd
	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr = 3'd3,
		opXor = 3'd4,
		opSlt = 3'd5
	} aluOp_t;

	// operand source for the execute stage
	// fwdNone takes the value read in decode
	// fwdMemWb is the older producer, fwdExMem the younger one
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdMemWb = 2'b01,
		fwdExMem = 2'b10
	} fwdSel_t;

endpackage

`default_nettype wire

//--- hw/instrIntake.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module instrIntake (
	input wire logic clk,
	input wire logic reset,
	input wire logic instrReq,
	input wire logic [`DATA_W-1:0] instrWord,
	input wire logic issueEnable,
	output logic instrAck,
	output logic issueValid,
	output logic [`DATA_W-1:0] issueWord
);

	localparam int ptrW = $clog2(`INTAKE_DEPTH);
	localparam int cntW = $clog2(`INTAKE_DEPTH + 1);

	// handshake phases, ack is high only in waitRelease
	typedef enum logic {
		waitReq,
		waitRelease
	} hsState_t;

	hsState_t state;
	logic [`DATA_W-1:0] queueMem [0:`INTAKE_DEPTH-1];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (count == cntW'(`INTAKE_DEPTH));
	assign empty = (count == '0);
	// capture only on a fresh req with room left, otherwise ack waits
	assign push = (state == waitReq) && instrReq && !full;
	// no stall path, the pipeline takes every issued word
	assign pop = issueEnable && !empty;

	assign instrAck = (state == waitRelease);
	assign issueValid = pop;
	assign issueWord = queueMem[rdPtr];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= waitReq;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			case (state)
				waitReq: if (push) state <= waitRelease;
				waitRelease: if (!instrReq) state <= waitReq;
				default: state <= waitReq;
			endcase
			if (push) begin
				wrPtr <= (wrPtr == ptrW'(`INTAKE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrW'(`INTAKE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// occupancy, push and pop together leave it unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// queue storage
	always_ff @(posedge clk) begin
		if (push) queueMem[wrPtr] <= instrWord;
	end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module regFile (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`REG_ADDR_W-1:0] readAddrA,
	input wire logic [`REG_ADDR_W-1:0] readAddrB,
	input wire logic [`REG_ADDR_W-1:0] writeAddr,
	input wire logic writeEn,
	input wire logic [`DATA_W-1:0] writeData,
	output logic [`DATA_W-1:0] readDataA,
	output logic [`DATA_W-1:0] readDataB
);

	logic [`DATA_W-1:0] regs [0:`NUM_REGS-1];

	// one read port
	// r0 reads zero, a write to the same index this cycle is passed through
	function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0) begin
			return '0;
		end else if (writeEn && (writeAddr == addr)) begin
			return writeData;
		end else begin
			return regs[addr];
		end
	endfunction

	assign readDataA = readPort(readAddrA);
	assign readDataB = readPort(readAddrB);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			// r0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- hw/forwardingUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module forwardingUnit (
	input wire logic [`REG_ADDR_W-1:0] idExRs,
	input wire logic [`REG_ADDR_W-1:0] idExRt,
	input wire logic [`REG_ADDR_W-1:0] exMemRd,
	input wire logic [`REG_ADDR_W-1:0] memWbRd,
	input wire logic exMemRegWrite,
	input wire logic memWbRegWrite,
	output pipePkg::fwdSel_t forwardA,
	output pipePkg::fwdSel_t forwardB
);

	import pipePkg::*;

	logic exMemLive;
	logic memWbLive;

	// source select for one operand
	// the younger producer in EX/MEM beats MEM/WB
	function automatic fwdSel_t selectSource(input logic [`REG_ADDR_W-1:0] src);
		if (exMemLive && (exMemRd == src)) begin
			return fwdExMem;
		end else if (memWbLive && (memWbRd == src)) begin
			return fwdMemWb;
		end else begin
			return fwdNone;
		end
	endfunction

	// a write to r0 never forwards
	assign exMemLive = exMemRegWrite && (exMemRd != '0);
	assign memWbLive = memWbRegWrite && (memWbRd != '0);

	// combinational, so the select lands in the same execute cycle
	always_comb begin
		forwardA = selectSource(idExRs);
		forwardB = selectSource(idExRt);
	end

	// a stage that reaches the regfile in decode already hits the bypass
	// so distance three needs nothing from here

endmodule

`default_nettype wire

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module aluUnit (
	input wire pipePkg::aluOp_t op,
	input wire logic [`DATA_W-1:0] operandA,
	input wire logic [`DATA_W-1:0] operandB,
	output logic [`DATA_W-1:0] result
);

	import pipePkg::*;

	logic lessThan;

	// signed compare for SLT
	assign lessThan = ($signed(operandA) < $signed(operandB));

	always_comb begin
		case (op)
			// add and sub wrap without an overflow trap
			opAdd: result = operandA + operandB;
			opSub: result = operandA - operandB;
			opAnd: result = operandA & operandB;
			opOr: result = operandA | operandB;
			opXor: result = operandA ^ operandB;
			// one or zero
			opSlt: result = {{(`DATA_W-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/aluPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module aluPipeline (
	input wire logic clk,
	input wire logic reset,
	input wire logic instrReq,
	input wire logic [`DATA_W-1:0] instrWord,
	input wire logic issueEnable,
	output logic instrAck,
	output logic wbValid,
	output logic [`REG_ADDR_W-1:0] wbReg,
	output logic [`DATA_W-1:0] wbData
);

	import pipePkg::*;

	// instruction field encodings
	localparam logic [5:0] opcodeRType = 6'h00;
	localparam logic [5:0] opcodeAddi = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2A;

	logic issueValid;
	logic [`DATA_W-1:0] issueWord;

	// decode
	logic [5:0] decOpcode;
	logic [5:0] decFunct;
	logic [`REG_ADDR_W-1:0] decRs;
	logic [`REG_ADDR_W-1:0] decRt;
	logic [`REG_ADDR_W-1:0] decRd;
	logic [`REG_ADDR_W-1:0] decDest;
	logic [`DATA_W-1:0] decImm;
	logic decUseImm;
	aluOp_t decOp;
	logic [`DATA_W-1:0] readDataA;
	logic [`DATA_W-1:0] readDataB;

	// ID/EX
	logic idExValid;
	logic [`REG_ADDR_W-1:0] idExRs;
	logic [`REG_ADDR_W-1:0] idExRt;
	logic [`REG_ADDR_W-1:0] idExDest;
	logic [`DATA_W-1:0] idExOperandA;
	logic [`DATA_W-1:0] idExOperandB;
	logic [`DATA_W-1:0] idExImm;
	logic idExUseImm;
	aluOp_t idExOp;

	// execute
	fwdSel_t forwardA;
	fwdSel_t forwardB;
	logic [`DATA_W-1:0] exOperandA;
	logic [`DATA_W-1:0] exRegOperandB;
	logic [`DATA_W-1:0] exOperandB;
	logic [`DATA_W-1:0] exResult;

	// EX/MEM and MEM/WB
	logic exMemValid;
	logic [`REG_ADDR_W-1:0] exMemDest;
	logic [`DATA_W-1:0] exMemResult;
	logic memWbValid;
	logic [`REG_ADDR_W-1:0] memWbDest;
	logic [`DATA_W-1:0] memWbResult;

	instrIntake intake (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrWord(instrWord),
		.issueEnable(issueEnable),
		.instrAck(instrAck),
		.issueValid(issueValid),
		.issueWord(issueWord)
	);

	// field split
	assign decOpcode = issueWord[31:26];
	assign decRs = issueWord[25:21];
	assign decRt = issueWord[20:16];
	assign decRd = issueWord[15:11];
	assign decFunct = issueWord[5:0];
	assign decImm = {{(`DATA_W-16){issueWord[15]}}, issueWord[15:0]};

	// anything unsupported falls through as ADD into r0
	always_comb begin
		decOp = opAdd;
		decDest = '0;
		decUseImm = 1'b0;
		case (decOpcode)
			opcodeRType: begin
				decDest = decRd;
				case (decFunct)
					fnAdd: decOp = opAdd;
					fnSub: decOp = opSub;
					fnAnd: decOp = opAnd;
					fnOr: decOp = opOr;
					fnXor: decOp = opXor;
					fnSlt: decOp = opSlt;
					default: decDest = '0;
				endcase
			end
			opcodeAddi: begin
				// rt is the destination here
				decDest = decRt;
				decUseImm = 1'b1;
			end
			default: decDest = '0;
		endcase
	end

	// write port from MEM/WB, same edge as the writeback port
	regFile regs (
		.clk(clk),
		.reset(reset),
		.readAddrA(decRs),
		.readAddrB(decRt),
		.writeAddr(memWbDest),
		.writeEn(memWbValid),
		.writeData(memWbResult),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	forwardingUnit fwd (
		.idExRs(idExRs),
		.idExRt(idExRt),
		.exMemRd(exMemDest),
		.memWbRd(memWbDest),
		.exMemRegWrite(exMemValid),
		.memWbRegWrite(memWbValid),
		.forwardA(forwardA),
		.forwardB(forwardB)
	);

	// operand muxes
	always_comb begin
		case (forwardA)
			fwdExMem: exOperandA = exMemResult;
			fwdMemWb: exOperandA = memWbResult;
			default: exOperandA = idExOperandA;
		endcase
		case (forwardB)
			fwdExMem: exRegOperandB = exMemResult;
			fwdMemWb: exRegOperandB = memWbResult;
			default: exRegOperandB = idExOperandB;
		endcase
	end

	// ADDI replaces the register operand
	assign exOperandB = idExUseImm ? idExImm : exRegOperandB;

	aluUnit alu (
		.op(idExOp),
		.operandA(exOperandA),
		.operandB(exOperandB),
		.result(exResult)
	);

	// stage valids and writeback strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			idExValid <= 1'b0;
			exMemValid <= 1'b0;
			memWbValid <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			idExValid <= issueValid;
			exMemValid <= idExValid;
			memWbValid <= exMemValid;
			wbValid <= memWbValid;
		end
	end

	// payload, qualified by the valids above
	always_ff @(posedge clk) begin
		idExRs <= decRs;
		idExRt <= decRt;
		idExDest <= decDest;
		idExOperandA <= readDataA;
		idExOperandB <= readDataB;
		idExImm <= decImm;
		idExUseImm <= decUseImm;
		idExOp <= decOp;
		exMemDest <= idExDest;
		exMemResult <= exResult;
		// memory slot only carries the result
		memWbDest <= exMemDest;
		memWbResult <= exMemResult;
		wbReg <= memWbDest;
		wbData <= memWbResult;
	end

endmodule

`default_nettype wire

//--- verif/aluPipelineTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_params.svh"

module aluPipelineTb #(
	parameter logic [31:0] seedValue = 32'ha5b9_457c
);

	// instruction encodings
	localparam logic [5:0] opR = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] fAdd = 6'h20;
	localparam logic [5:0] fSub = 6'h22;
	localparam logic [5:0] fAnd = 6'h24;
	localparam logic [5:0] fOr = 6'h25;
	localparam logic [5:0] fXor = 6'h26;
	localparam logic [5:0] fSlt = 6'h2A;

	// wait limits in cycles
	localparam int ackTimeout = 20;
	localparam int drainTimeout = 200;
	localparam int fullWindow = 12;
	localparam int quietWindow = 4;

	logic clk;
	logic reset;
	logic instrReq;
	logic [`DATA_W-1:0] instrWord;
	logic issueEnable;
	logic instrAck;
	logic wbValid;
	logic [`REG_ADDR_W-1:0] wbReg;
	logic [`DATA_W-1:0] wbData;

	// reference register state in program order
	logic [`DATA_W-1:0] model [0:`NUM_REGS-1];
	logic [`REG_ADDR_W-1:0] expRegQ [$];
	logic [`DATA_W-1:0] expDataQ [$];
	logic [`REG_ADDR_W-1:0] headReg;
	logic [`DATA_W-1:0] headData;
	logic prevReq;
	int sentCount;
	int retireCount;
	int startRetired;
	int sent;
	int burst;
	integer seed;

	aluPipeline dut_i (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrWord(instrWord),
		.issueEnable(issueEnable),
		.instrAck(instrAck),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	// expected ALU result per funct
	function automatic logic [`DATA_W-1:0] computeR(input logic [5:0] funct,
		input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
		case (funct)
			fSub: return a - b;
			fAnd: return a & b;
			fOr: return a | b;
			fXor: return a ^ b;
			fSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	// r0 retires but never changes
	task automatic recordExpected(input logic [`REG_ADDR_W-1:0] dest,
		input logic [`DATA_W-1:0] value);
		expRegQ.push_back(dest);
		expDataQ.push_back(value);
		sentCount++;
		if (dest != 5'd0) model[dest] = value;
	endtask

	task automatic waitAckLevel(input logic level);
		int waited;
		waited = 0;
		while (instrAck !== level && waited < ackTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (instrAck !== level) begin
			if (level) stopOnFailure("timed out waiting for instrAck to rise");
			else stopOnFailure("timed out waiting for instrAck to fall");
		end
	endtask

	// full four-phase cycle for one word
	task automatic sendWord(input logic [`DATA_W-1:0] word);
		instrWord = word;
		instrReq = 1'b1;
		waitAckLevel(1'b1);
		instrReq = 1'b0;
		waitAckLevel(1'b0);
	endtask

	task automatic sendRType(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		recordExpected(rd, computeR(funct, model[rs], model[rt]));
		sendWord({opR, rs, rt, rd, 5'd0, funct});
	endtask

	task automatic sendAddi(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		recordExpected(rt, model[rs] + {{16{imm[15]}}, imm});
		sendWord({opAddi, rs, rt, imm});
	endtask

	// ADD r0, r0, r0
	task automatic sendNop();
		sendRType(fAdd, 5'd0, 5'd0, 5'd0);
	endtask

	task automatic sendThreeNops();
		sendNop();
		sendNop();
		sendNop();
	endtask

	// let the queue issue until every expected writeback is seen
	task automatic drainQueue();
		int waited;
		issueEnable = 1'b1;
		waited = 0;
		while (expRegQ.size() != 0 && waited < drainTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expRegQ.size() != 0) stopOnFailure("pipeline did not retire the queued words in time");
		else issueEnable = 1'b0;
	endtask

	// issue until the random program has retired the given number of instructions
	task automatic waitRetired(input int target);
		int waited;
		issueEnable = 1'b1;
		waited = 0;
		while ((retireCount - startRetired) != target && waited < drainTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if ((retireCount - startRetired) != target) begin
			stopOnFailure($sformatf(
				"random program retired %0d of %0d instructions before the timeout",
				retireCount - startRetired, target));
		end else begin
			issueEnable = 1'b0;
		end
	endtask

	// one supported instruction over r0..r7
	task automatic sendRandom();
		logic [31:0] pick;
		logic [31:0] fields;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		pick = $random(seed);
		fields = $random(seed);
		rd = {2'b00, fields[2:0]};
		rs = {2'b00, fields[5:3]};
		rt = {2'b00, fields[8:6]};
		case (pick % 32'd7)
			32'd0: sendRType(fAdd, rd, rs, rt);
			32'd1: sendRType(fSub, rd, rs, rt);
			32'd2: sendRType(fAnd, rd, rs, rt);
			32'd3: sendRType(fOr, rd, rs, rt);
			32'd4: sendRType(fXor, rd, rs, rt);
			32'd5: sendRType(fSlt, rd, rs, rt);
			default: sendAddi(rt, rs, fields[31:16]);
		endcase
	endtask

	// handshake protocol and writeback checks sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			// ack may outlive req by one cycle only
			assert (instrAck === 1'b0 || instrReq || prevReq)
				else stopOnFailure("instrAck high without a request in this or the last cycle");
			if (wbValid) begin
				if (expRegQ.size() == 0) begin
					stopOnFailure("writeback seen with no instruction outstanding");
				end else begin
					headReg = expRegQ.pop_front();
					headData = expDataQ.pop_front();
					retireCount++;
					assert (wbReg == headReg) else stopOnFailure($sformatf(
						"ERR time=%0t signal=wbReg expected=%0d actual=%0d",
						$time, headReg, wbReg));
					assert (wbData == headData) else stopOnFailure($sformatf(
						"ERR time=%0t signal=wbData expected=%h actual=%h",
						$time, headData, wbData));
				end
			end
		end
		prevReq = instrReq;
	end

	initial begin
		seed = seedValue;
		reset = 1'b1;
		instrReq = 1'b0;
		instrWord = '0;
		issueEnable = 1'b0;
		prevReq = 1'b0;
		sentCount = 0;
		retireCount = 0;
		for (int i = 0; i < `NUM_REGS; i++) model[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// eight words fill the queue for the back-pressure check
		sendAddi(5'd1, 5'd0, 16'd5);
		sendAddi(5'd2, 5'd0, 16'hfffd);
		sendAddi(5'd3, 5'd0, 16'h7fff);
		sendAddi(5'd4, 5'd0, 16'h8000);
		sendAddi(5'd5, 5'd0, 16'd100);
		sendAddi(5'd6, 5'd0, 16'hffff);
		sendAddi(5'd7, 5'd0, 16'h1234);
		sendAddi(5'd8, 5'd0, 16'h00f0);
		// ninth word has to wait for room
		recordExpected(5'd9, 32'd900);
		instrWord = {opAddi, 5'd0, 5'd9, 16'd900};
		instrReq = 1'b1;
		for (int i = 0; i < fullWindow; i++) begin
			@(posedge clk);
			#1;
			assert (!instrAck) else stopOnFailure("instrAck rose while the intake queue was full");
		end
		issueEnable = 1'b1;
		waitAckLevel(1'b1);
		instrReq = 1'b0;
		waitAckLevel(1'b0);
		drainQueue();

		// independent ops three NOPs apart
		issueEnable = 1'b1;
		sendRType(fAdd, 5'd10, 5'd1, 5'd2);
		sendThreeNops();
		sendRType(fSub, 5'd11, 5'd2, 5'd3);
		sendThreeNops();
		sendRType(fAnd, 5'd12, 5'd6, 5'd7);
		sendThreeNops();
		sendRType(fOr, 5'd13, 5'd7, 5'd8);
		sendThreeNops();
		sendRType(fXor, 5'd14, 5'd3, 5'd6);
		sendThreeNops();
		// slt with negatives on either side
		sendRType(fSlt, 5'd15, 5'd2, 5'd1);
		sendThreeNops();
		sendRType(fSlt, 5'd16, 5'd1, 5'd2);
		sendThreeNops();
		sendRType(fSlt, 5'd17, 5'd4, 5'd2);
		sendThreeNops();
		sendRType(fSlt, 5'd18, 5'd2, 5'd4);
		drainQueue();

		// EX/MEM chain queued so it issues back to back
		sendAddi(5'd20, 5'd0, 16'd3);
		sendRType(fAdd, 5'd21, 5'd20, 5'd1);
		sendRType(fSub, 5'd22, 5'd5, 5'd21);
		sendRType(fAdd, 5'd23, 5'd22, 5'd22);
		sendRType(fSlt, 5'd24, 5'd23, 5'd2);
		sendRType(fXor, 5'd25, 5'd24, 5'd24);
		sendRType(fOr, 5'd26, 5'd25, 5'd7);
		drainQueue();

		// distance two and then two producers of r29
		sendAddi(5'd27, 5'd0, 16'd11);
		sendNop();
		sendRType(fAdd, 5'd28, 5'd27, 5'd1);
		sendAddi(5'd29, 5'd0, 16'd1);
		sendAddi(5'd29, 5'd0, 16'd2);
		sendRType(fAdd, 5'd30, 5'd1, 5'd29);
		drainQueue();
		// MEM/WB beats the bypass and then plain distance three
		sendAddi(5'd31, 5'd0, 16'd40);
		sendAddi(5'd31, 5'd0, 16'd50);
		sendNop();
		sendRType(fSub, 5'd27, 5'd31, 5'd1);
		sendAddi(5'd9, 5'd0, 16'd77);
		sendNop();
		sendNop();
		sendRType(fAdd, 5'd28, 5'd9, 5'd9);
		drainQueue();

		// writes to r0 must not forward
		sendAddi(5'd0, 5'd0, 16'h0055);
		sendRType(fAdd, 5'd10, 5'd0, 5'd1);
		sendRType(fOr, 5'd0, 5'd1, 5'd7);
		sendRType(fAdd, 5'd11, 5'd0, 5'd0);
		sendNop();
		sendRType(fSub, 5'd12, 5'd6, 5'd0);
		drainQueue();

		// random program in random-size bursts
		startRetired = retireCount;
		sent = 0;
		while (sent < 64) begin
			burst = int'($unsigned($random(seed)) % 32'd8) + 1;
			for (int b = 0; b < burst && sent < 64; b++) begin
				sendRandom();
				sent++;
			end
			waitRetired(sent);
		end

		// room for a stray writeback to reach the checker after the last burst
		repeat (quietWindow) @(posedge clk);
		#1;

		if (expRegQ.size() == 0 && retireCount == sentCount) begin
			$display("All tests passed!");
			$finish;
		end else begin
			stopOnFailure("writebacks still outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/pipePkg.sv
hw/instrIntake.sv
hw/regFile.sv
hw/forwardingUnit.sv
hw/aluUnit.sv
hw/aluPipeline.sv
verif/aluPipelineTb.sv

//--- Makefile
# Verilator simulation of the ALU pipeline
VERILATOR ?= verilator
TOP ?= aluPipelineTb
FLIST ?= flist.f
SEED ?= 32'ha5b9457c
OBJDIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= All tests passed!

.PHONY: sim clean

# build, run, and pass only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FLIST) -GseedValue="$(SEED)"
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
